/* build.f */
hdl/dot8_pkg.sv
hdl/product_stage.sv
hdl/adder_tree.sv
hdl/pipe_control.sv
hdl/result_accumulator.sv
hdl/dot8_top.sv
bench/dot8_tb.sv

/* bench/dot8_tb.sv */
// Dot8 testbench
`timescale 1ns/1ns

module dot8_tb;
   import dot8_pkg::*;

   logic        clk;
   logic        rst;
   logic        in_valid;
   logic        in_ready;
   logic        in_last;
   logic [15:0] op_0;
   logic [15:0] op_1;
   logic [15:0] op_2;
   logic [15:0] op_3;
   logic [15:0] op_4;
   logic [15:0] op_5;
   logic [15:0] op_6;
   logic [15:0] op_7;
   logic        result_valid;
   logic        result_ready;
   logic [15:0] result;
   acc_state_t  acc_state;

   // Reference queue as a ring, one entry per finished group
   logic [15:0] exp_mem [256];
   int          exp_cyc [256];
   logic [7:0]  wr_ptr;
   logic [7:0]  rd_ptr;
   logic [15:0] exp_head;
   int          head_cyc;
   logic [15:0] group_acc;
   logic [15:0] group_new;
   int          cycle_cnt;
   int          stall_cnt;

   // Stimulus streams and output modes
   logic [15:0] stim_lfsr;
   logic [15:0] ready_lfsr;
   logic [31:0] ready_bits;
   logic        ready_random;
   logic        ready_fixed;

   dot8_top #(.WIDTH(16)) dut_i (
      .clk          (clk),
      .rst          (rst),
      .in_valid     (in_valid),
      .in_ready     (in_ready),
      .in_last      (in_last),
      .op_0         (op_0),
      .op_1         (op_1),
      .op_2         (op_2),
      .op_3         (op_3),
      .op_4         (op_4),
      .op_5         (op_5),
      .op_6         (op_6),
      .op_7         (op_7),
      .result_valid (result_valid),
      .result_ready (result_ready),
      .result       (result),
      .acc_state    (acc_state)
   );

   always #2 clk = ~clk;

   assign exp_head = exp_mem[rd_ptr];
   assign head_cyc = exp_cyc[rd_ptr];

   // ========================================================================
   // Helpers
   // ========================================================================

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1);
   endtask

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit taken
   task automatic rand_bits(inout logic [15:0] st, input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v  = {v[30:0], st[15]};
         st = lfsr_next(st);
      end
   endtask

   // Four pair products summed, low 16 bits kept
   function automatic logic [15:0] beat_sum(input logic [127:0] ops);
      logic [31:0] acc;
      acc = 32'd0;
      for (int k = 0; k < 4; k++) begin
         acc = acc + ops[32*k +: 16] * ops[32*k+16 +: 16];
      end
      return acc[15:0];
   endfunction

   // Called at a rising edge, returns at the accepting edge
   task automatic send_beat(input logic [127:0] ops, input logic last);
      int waited;
      in_valid <= 1'b1;
      in_last  <= last;
      op_0 <= ops[15:0];
      op_1 <= ops[31:16];
      op_2 <= ops[47:32];
      op_3 <= ops[63:48];
      op_4 <= ops[79:64];
      op_5 <= ops[95:80];
      op_6 <= ops[111:96];
      op_7 <= ops[127:112];
      waited = 0;
      // in_ready is settled at the falling edge
      @(negedge clk);
      while (!in_ready) begin
         waited++;
         if (waited > 200) begin
            fail_run("Timed out waiting for in_ready");
         end
         @(negedge clk);
      end
      @(posedge clk);
   endtask

   task automatic send_group(input int len, input bit all_max, input bit with_gaps);
      logic [127:0] ops;
      logic [31:0]  v;
      int           gap;
      for (int b = 0; b < len; b++) begin
         if (all_max) begin
            ops = '1;
         end else begin
            for (int k = 0; k < 8; k++) begin
               rand_bits(stim_lfsr, 16, v);
               ops[16*k +: 16] = v[15:0];
            end
         end
         send_beat(ops, b == len - 1);
         gap = 0;
         if (with_gaps) begin
            // Half of the beats go back to back
            rand_bits(stim_lfsr, 2, v);
            gap = (v[1:0] < 2) ? 0 : v[1:0] - 1;
         end
         if (gap > 0) begin
            in_valid <= 1'b0;
            repeat (gap) @(posedge clk);
         end
      end
   endtask

   task automatic send_random_groups(input int count, input bit with_gaps);
      logic [31:0] v;
      for (int g = 0; g < count; g++) begin
         rand_bits(stim_lfsr, 2, v);
         send_group(v[1:0] + 1, 1'b0, with_gaps);
      end
   endtask

   // All groups delivered and nothing held
   task automatic wait_drained();
      int waited;
      in_valid <= 1'b0;
      waited = 0;
      @(negedge clk);
      while (wr_ptr != rd_ptr || result_valid) begin
         waited++;
         if (waited > 500) begin
            fail_run("Timed out waiting for outstanding results to drain");
         end
         @(negedge clk);
      end
      // Every group closed and taken, so the accumulator is empty
      a_drained_idle : assert (acc_state == acc_idle)
         else fail_run($sformatf("Mismatch on acc_state after drain: got %h expected %h",
                                 acc_state, acc_idle));
      @(posedge clk);
   endtask

   // ========================================================================
   // Reference model and output driver
   // ========================================================================

   always @(posedge clk) begin
      if (rst) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         group_acc <= '0;
         cycle_cnt <= 0;
         stall_cnt <= 0;
      end else begin
         cycle_cnt <= cycle_cnt + 1;
         if (!in_ready) begin
            stall_cnt <= stall_cnt + 1;
         end
         if (in_valid && in_ready) begin
            group_new = group_acc + beat_sum({op_7, op_6, op_5, op_4,
                                              op_3, op_2, op_1, op_0});
            if (in_last) begin
               exp_mem[wr_ptr] <= group_new;
               exp_cyc[wr_ptr] <= cycle_cnt;
               wr_ptr          <= wr_ptr + 1'b1;
               group_acc       <= '0;
            end else begin
               group_acc <= group_new;
            end
         end
         if (result_valid && result_ready) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // Ready low on about one cycle in four when random
   always @(posedge clk) begin
      if (ready_random) begin
         rand_bits(ready_lfsr, 2, ready_bits);
         result_ready <= ready_bits[1:0] != 2'b00;
      end else begin
         result_ready <= 1'b1;
      end
   end

   // ========================================================================
   // Checks
   // ========================================================================

   // Reset values are visible from the second edge of reset onwards
   a_reset_valid : assert property (@(posedge clk)
      ((rst && $past(rst)) || $fell(rst)) |-> !result_valid)
      else fail_run($sformatf("Mismatch on result_valid around reset: got %h expected 0",
                              $sampled(result_valid)));

   a_reset_ready : assert property (@(posedge clk)
      ((rst && $past(rst)) || $fell(rst)) |-> in_ready)
      else fail_run($sformatf("Mismatch on in_ready around reset: got %h expected 1",
                              $sampled(in_ready)));

   a_reset_state : assert property (@(posedge clk)
      ((rst && $past(rst)) || $fell(rst)) |-> acc_state == acc_idle)
      else fail_run($sformatf("Mismatch on acc_state around reset: got %h expected %h",
                              $sampled(acc_state), acc_idle));

   // A presented total means the FSM is holding it
   a_state_hold : assert property (@(posedge clk) disable iff (rst)
      result_valid |-> acc_state == acc_hold)
      else fail_run($sformatf("Mismatch on acc_state while result held: got %h expected %h",
                              $sampled(acc_state), acc_hold));

   a_result_owed : assert property (@(posedge clk) disable iff (rst)
      result_valid && result_ready |-> wr_ptr != rd_ptr)
      else fail_run("A result was delivered while no group was outstanding");

   a_result_value : assert property (@(posedge clk) disable iff (rst)
      result_valid && result_ready |-> result == exp_head)
      else fail_run($sformatf("Mismatch on result: got %h expected %h",
                              $sampled(result), $sampled(exp_head)));

   // Only checked while result_ready is tied high
   a_result_latency : assert property (@(posedge clk) disable iff (rst)
      result_valid && result_ready && ready_fixed |-> cycle_cnt - head_cyc == 5)
      else fail_run($sformatf("Mismatch on result latency: got %h expected %h",
                              $sampled(cycle_cnt) - $sampled(head_cyc), 5));

   a_result_stable : assert property (@(posedge clk) disable iff (rst)
      result_valid && !result_ready |=> result_valid && $stable(result))
      else fail_run("Held result changed or was dropped before it was taken");

   a_stall_cause : assert property (@(posedge clk) disable iff (rst)
      !in_ready |-> result_valid && !result_ready)
      else fail_run("in_ready went low without a held, untaken result");

   // ========================================================================
   // Sequence
   // ========================================================================

   initial begin
      clk          = 1'b0;
      rst          = 1'b1;
      in_valid     = 1'b0;
      in_last      = 1'b0;
      {op_0, op_1, op_2, op_3, op_4, op_5, op_6, op_7} = '0;
      result_ready = 1'b0;
      ready_random = 1'b0;
      ready_fixed  = 1'b1;
      stim_lfsr    = 16'd6461;
      ready_lfsr   = 16'd6461;

      repeat (10) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);

      // Single-beat groups, output always ready
      for (int g = 0; g < 6; g++) begin
         send_group(1, 1'b0, 1'b1);
      end
      wait_drained();

      // Multi-beat groups, then an all-ones group to force wrap
      send_random_groups(5, 1'b1);
      send_group(3, 1'b1, 1'b0);
      wait_drained();

      // Back-pressure with gaps and back-to-back beats
      ready_fixed  <= 1'b0;
      ready_random <= 1'b1;
      send_random_groups(40, 1'b1);
      wait_drained();

      if (stall_cnt == 0) begin
         fail_run("Back-pressure phase never stalled the pipeline");
      end else begin
         $display("*** PASSED ***");
         $finish;
      end
   end

endmodule

/* hdl/dot8_top.sv */
// Dot8 multiply-accumulate top
`timescale 1ns/1ns

module dot8_top #(
   parameter int WIDTH = 16
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 in_valid,
   output logic                 in_ready,
   input  logic                 in_last,
   input  logic [WIDTH-1:0]     op_0,
   input  logic [WIDTH-1:0]     op_1,
   input  logic [WIDTH-1:0]     op_2,
   input  logic [WIDTH-1:0]     op_3,
   input  logic [WIDTH-1:0]     op_4,
   input  logic [WIDTH-1:0]     op_5,
   input  logic [WIDTH-1:0]     op_6,
   input  logic [WIDTH-1:0]     op_7,
   output logic                 result_valid,
   input  logic                 result_ready,
   output logic [WIDTH-1:0]     result,
   output dot8_pkg::acc_state_t acc_state
);
   import dot8_pkg::*;

   // Ports above are wired for eight operands in four pairs
   if (NUM_OPERANDS != 2 * NUM_PRODUCTS) begin : g_bad_geometry
      $error("dot8_top expects two operands per product");
   end

   logic             advance;
   logic             sum_valid;
   logic             sum_last;
   logic             hold_full;
   logic [WIDTH-1:0] prod_0;
   logic [WIDTH-1:0] prod_1;
   logic [WIDTH-1:0] prod_2;
   logic [WIDTH-1:0] prod_3;
   logic [WIDTH-1:0] sum;

   // ========================================================================
   // Control and datapath
   // ========================================================================

   pipe_control ctrl_i (
      .clk          (clk),
      .rst          (rst),
      .in_valid     (in_valid),
      .in_last      (in_last),
      .hold_full    (hold_full),
      .result_ready (result_ready),
      .in_ready     (in_ready),
      .advance      (advance),
      .sum_valid    (sum_valid),
      .sum_last     (sum_last)
   );

   product_stage #(.WIDTH(WIDTH)) prod_i (
      .clk     (clk),
      .rst     (rst),
      .advance (advance),
      .op_0    (op_0),
      .op_1    (op_1),
      .op_2    (op_2),
      .op_3    (op_3),
      .op_4    (op_4),
      .op_5    (op_5),
      .op_6    (op_6),
      .op_7    (op_7),
      .prod_0  (prod_0),
      .prod_1  (prod_1),
      .prod_2  (prod_2),
      .prod_3  (prod_3)
   );

   adder_tree #(.WIDTH(WIDTH)) tree_i (
      .clk     (clk),
      .rst     (rst),
      .advance (advance),
      .prod_0  (prod_0),
      .prod_1  (prod_1),
      .prod_2  (prod_2),
      .prod_3  (prod_3),
      .sum     (sum)
   );

   // Accumulator sees the sum alongside its flags from the control chain
   result_accumulator #(.WIDTH(WIDTH)) acc_i (
      .clk          (clk),
      .rst          (rst),
      .sum_valid    (sum_valid),
      .sum_last     (sum_last),
      .sum          (sum),
      .result_ready (result_ready),
      .hold_full    (hold_full),
      .result_valid (result_valid),
      .result       (result),
      .state        (acc_state)
   );

endmodule

/* hdl/result_accumulator.sv */
// Group total accumulator
`timescale 1ns/1ns

module result_accumulator #(
   parameter int WIDTH = 16
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 sum_valid,
   input  logic                 sum_last,
   input  logic [WIDTH-1:0]     sum,
   input  logic                 result_ready,
   output logic                 hold_full,
   output logic                 result_valid,
   output logic [WIDTH-1:0]     result,
   output dot8_pkg::acc_state_t state
);
   import dot8_pkg::*;

   acc_state_t       next_state;
   logic [WIDTH-1:0] run_sum;
   logic [WIDTH-1:0] beat_total;
   logic             stall;
   logic             take;

   assign hold_full    = (state == acc_hold);
   assign result_valid = hold_full;

   // Same condition that freezes the pipeline upstream
   assign stall = hold_full && !result_ready;
   // Beat at the tree output is consumed only on an advancing cycle
   assign take  = sum_valid && !stall;

   // Running sum plus this beat, wraps at WIDTH
   assign beat_total = run_sum + sum;

   // ========================================================================
   // FSM
   // ========================================================================

   always_comb begin
      next_state = state;
      case (state)
         acc_idle, acc_sum: begin
            if (take) begin
               next_state = sum_last ? acc_hold : acc_sum;
            end
         end
         acc_hold: begin
            // take implies result_ready here, so the held total leaves
            if (take) begin
               next_state = sum_last ? acc_hold : acc_sum;
            end else if (result_ready) begin
               next_state = acc_idle;
            end
         end
         default: begin
            next_state = acc_idle;
         end
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state   <= acc_idle;
         run_sum <= '0;
      end else begin
         state <= next_state;
         if (take) begin
            // Last beat closes the group and starts the next from zero
            run_sum <= sum_last ? '0 : beat_total;
         end
      end
   end

   // Output register, loaded with the group total on a last beat
   always_ff @(posedge clk) begin
      if (take && sum_last) begin
         result <= beat_total;
      end
   end

   // Held total must not move until it is taken
   a_hold_stable : assert property (@(posedge clk) disable iff (rst)
      result_valid && !result_ready |=> result_valid && $stable(result));

endmodule

/* hdl/pipe_control.sv */
// Pipeline valid tracking and stall
`timescale 1ns/1ns

module pipe_control (
   input  logic clk,
   input  logic rst,
   input  logic in_valid,
   input  logic in_last,
   input  logic hold_full,
   input  logic result_ready,
   output logic in_ready,
   output logic advance,
   output logic sum_valid,
   output logic sum_last
);
   import dot8_pkg::*;

   localparam int CNT_W = $clog2(PIPE_LATENCY + 1);

   stage_flags_t           valid_flags;
   stage_flags_t           last_flags;
   // Advance history over the last PIPE_LATENCY cycles
   stage_flags_t           adv_hist;
   logic [CNT_W-1:0]       warm_cnt;

   // Freeze only while a finished total sits unclaimed
   assign advance  = !(hold_full && !result_ready);
   assign in_ready = advance;

   // ========================================================================
   // Valid and last chains
   // ========================================================================

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_flags <= '0;
         last_flags  <= '0;
      end else if (advance) begin
         // in_ready equals advance, so in_valid here means accepted
         valid_flags <= {valid_flags[PIPE_LATENCY-2:0], in_valid};
         last_flags  <= {last_flags[PIPE_LATENCY-2:0], in_valid && in_last};
      end
   end

   assign sum_valid = valid_flags[PIPE_LATENCY-1];
   assign sum_last  = last_flags[PIPE_LATENCY-1];

   // Cycles since reset, saturating at the latency
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         warm_cnt <= '0;
         adv_hist <= '0;
      end else begin
         if (warm_cnt < PIPE_LATENCY) begin
            warm_cnt <= warm_cnt + 1'b1;
         end
         adv_hist <= {adv_hist[PIPE_LATENCY-2:0], advance};
      end
   end

   // ========================================================================
   // Checks
   // ========================================================================

   // Nothing can reach the end of the chain before it fills
   a_warmup : assert property (@(posedge clk) disable iff (rst)
      warm_cnt < PIPE_LATENCY |-> !sum_valid);

   // Without a stall the chain is a plain delay line
   a_latency : assert property (@(posedge clk) disable iff (rst)
      (warm_cnt == PIPE_LATENCY && &adv_hist)
         |-> sum_valid == $past(in_valid && in_ready, PIPE_LATENCY));

endmodule

/* hdl/adder_tree.sv */
// Two-level product reduction
`timescale 1ns/1ns

module adder_tree #(
   parameter int WIDTH = 16
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             advance,
   input  logic [WIDTH-1:0] prod_0,
   input  logic [WIDTH-1:0] prod_1,
   input  logic [WIDTH-1:0] prod_2,
   input  logic [WIDTH-1:0] prod_3,
   output logic [WIDTH-1:0] sum
);
   import dot8_pkg::*;

   logic [WIDTH-1:0] prod_in [NUM_PRODUCTS];
   // First level halves the product count
   logic [WIDTH-1:0] lvl1_r  [NUM_PRODUCTS/2];
   logic [WIDTH-1:0] sum_r;

   assign prod_in = '{prod_0, prod_1, prod_2, prod_3};

   // Both levels move together with the rest of the pipeline
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < NUM_PRODUCTS/2; i++) begin
            lvl1_r[i] <= '0;
         end
         sum_r <= '0;
      end else if (advance) begin
         // Adjacent products, carry out dropped
         for (int i = 0; i < NUM_PRODUCTS/2; i++) begin
            lvl1_r[i] <= prod_in[2*i] + prod_in[2*i+1];
         end
         // Final level
         sum_r <= lvl1_r[0] + lvl1_r[1];
      end
   end

   assign sum = sum_r;

endmodule

/* hdl/product_stage.sv */
// Operand and product stages
`timescale 1ns/1ns

module product_stage #(
   parameter int WIDTH = 16
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             advance,
   input  logic [WIDTH-1:0] op_0,
   input  logic [WIDTH-1:0] op_1,
   input  logic [WIDTH-1:0] op_2,
   input  logic [WIDTH-1:0] op_3,
   input  logic [WIDTH-1:0] op_4,
   input  logic [WIDTH-1:0] op_5,
   input  logic [WIDTH-1:0] op_6,
   input  logic [WIDTH-1:0] op_7,
   output logic [WIDTH-1:0] prod_0,
   output logic [WIDTH-1:0] prod_1,
   output logic [WIDTH-1:0] prod_2,
   output logic [WIDTH-1:0] prod_3
);
   import dot8_pkg::*;

   // Loose operand ports gathered so the stages can loop
   logic [WIDTH-1:0] op_in  [NUM_OPERANDS];
   logic [WIDTH-1:0] op_r   [NUM_OPERANDS];
   logic [WIDTH-1:0] prod_r [NUM_PRODUCTS];

   assign op_in = '{op_0, op_1, op_2, op_3, op_4, op_5, op_6, op_7};

   // Stage 0 latches the beat, stage 1 multiplies neighbouring operands
   // Product keeps the low WIDTH bits only, so it wraps like the rest
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < NUM_OPERANDS; i++) begin
            op_r[i] <= '0;
         end
         for (int i = 0; i < NUM_PRODUCTS; i++) begin
            prod_r[i] <= '0;
         end
      end else if (advance) begin
         for (int i = 0; i < NUM_OPERANDS; i++) begin
            op_r[i] <= op_in[i];
         end
         // Pair k is op_2k times op_2k+1
         for (int i = 0; i < NUM_PRODUCTS; i++) begin
            prod_r[i] <= op_r[2*i] * op_r[2*i+1];
         end
      end
   end

   assign prod_0 = prod_r[0];
   assign prod_1 = prod_r[1];
   assign prod_2 = prod_r[2];
   assign prod_3 = prod_r[3];

endmodule

/* hdl/dot8_pkg.sv */
// Dot8 shared definitions

package dot8_pkg;

   // ========================================================================
   // Beat geometry
   // ========================================================================

   // Operands carried by one input beat
   localparam int NUM_OPERANDS = 8;

   // Operands are consumed in pairs, one product each
   localparam int NUM_PRODUCTS = 4;

   // Advancing cycles from acceptance until the sum leaves the adder tree
   // Operand reg, product reg, first-level sum reg, final sum reg
   localparam int PIPE_LATENCY = 4;

   // ========================================================================
   // Shared types
   // ========================================================================

   // One bit per pipeline stage, bit i set when stage i holds a live beat
   typedef logic [PIPE_LATENCY-1:0] stage_flags_t;

   // Result accumulator FSM
   typedef enum logic [1:0] {
      acc_idle,
      acc_sum,
      acc_hold
   } acc_state_t;

endpackage
